/* colorPkg.sv */
`default_nettype none

package colorPkg;

	localparam int CHAN_W  = 10;
	localparam int COORD_W = 11;
	localparam int COUNT_W = 21; // Enough for a full 1280x1024 frame

	typedef struct packed {
		logic [CHAN_W-1:0] r;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] b;
	} rgbPixel_t;

	// One pixel on the stream, valid is a strobe
	typedef struct packed {
		logic               valid;
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		rgbPixel_t          rgb;
	} pixelBeat_t;

	typedef struct packed {
		rgbPixel_t low;
		rgbPixel_t high;
	} colorWindow_t;

	// Also the bit order of the presence outputs
	typedef struct packed {
		logic red;
		logic yellow;
		logic green;
		logic window;
	} hueFlags_t;

	typedef struct packed {
		logic [COUNT_W-1:0] red;
		logic [COUNT_W-1:0] yellow;
		logic [COUNT_W-1:0] green;
		logic [COUNT_W-1:0] window;
	} frameCounts_t;

	localparam logic [CHAN_W-1:0]  CHAN_MAX = 10'd1023;
	localparam logic [CHAN_W-1:0]  TOL_BASE = 10'd85;
	localparam logic [COORD_W-1:0] CAL_X    = 11'd640; // Screen centre
	localparam logic [COORD_W-1:0] CAL_Y    = 11'd512;

	localparam rgbPixel_t HIGHLIGHT = '{r: CHAN_MAX, g: {CHAN_W{1'b0}}, b: CHAN_MAX}; // Magenta

	localparam logic [COUNT_W-1:0] MIN_PRESENT = 21'd16;

	// Classifier thresholds
	localparam logic [CHAN_W-1:0] RED_MIN       = 10'd256;
	localparam logic [CHAN_W-1:0] RED_OTHER_MAX = 10'd128;
	localparam logic [CHAN_W-1:0] YEL_RG_MIN    = 10'd256;
	localparam logic [CHAN_W-1:0] YEL_B_MAX     = 10'd128;
	localparam logic [CHAN_W-1:0] GRN_R_MAX     = 10'd100;
	localparam logic [CHAN_W-1:0] GRN_G_MIN     = 10'd140;
	localparam logic [CHAN_W-1:0] GRN_B_MAX     = 10'd256;

endpackage

`default_nettype wire

/* refSampler.sv */
`timescale 1ns/1ns
`default_nettype none

module refSampler
(
	input  logic                    CLK,
	input  logic                    rst,
	input  colorPkg::pixelBeat_t    pixIn,
	input  logic                    calibrate,
	input  logic [4:0]              tolStep,
	output colorPkg::rgbPixel_t     refColor,
	output colorPkg::colorWindow_t  window
);

	colorPkg::rgbPixel_t refQ;
	logic [colorPkg::CHAN_W-1:0] tol;
	logic calHit;

	// Lower edge, floored at zero
	function automatic logic [colorPkg::CHAN_W-1:0] lowBound
	(
		input logic [colorPkg::CHAN_W-1:0] refVal,
		input logic [colorPkg::CHAN_W-1:0] tolVal
	);
		logic [colorPkg::CHAN_W-1:0] res;
		if (refVal <= tolVal)
			res = '0;
		else
			res = refVal - tolVal;
		return res;
	endfunction

	// Upper edge, capped at full scale
	function automatic logic [colorPkg::CHAN_W-1:0] highBound
	(
		input logic [colorPkg::CHAN_W-1:0] refVal,
		input logic [colorPkg::CHAN_W-1:0] tolVal
	);
		logic [colorPkg::CHAN_W-1:0] res;
		if (refVal >= colorPkg::CHAN_MAX - tolVal)
			res = colorPkg::CHAN_MAX;
		else
			res = refVal + tolVal;
		return res;
	endfunction

	assign calHit = pixIn.valid && calibrate
		&& (pixIn.x == colorPkg::CAL_X) && (pixIn.y == colorPkg::CAL_Y);

	// Base plus four per step, at most 209
	assign tol = colorPkg::TOL_BASE + {{(colorPkg::CHAN_W-7){1'b0}}, tolStep, 2'b00};

	always_ff @(posedge CLK)
	begin
		if (rst)
			refQ <= '0;
		else if (calHit)
			refQ <= pixIn.rgb; // Grab the centre pixel
	end

	assign refColor = refQ;

	always_comb
	begin
		window.low.r  = lowBound(refQ.r, tol);
		window.low.g  = lowBound(refQ.g, tol);
		window.low.b  = lowBound(refQ.b, tol);
		window.high.r = highBound(refQ.r, tol);
		window.high.g = highBound(refQ.g, tol);
		window.high.b = highBound(refQ.b, tol); // Blue from blue
	end

endmodule

`default_nettype wire

/* windowMatch.sv */
`timescale 1ns/1ns
`default_nettype none

module windowMatch
(
	input  logic                    CLK,
	input  logic                    rst,
	input  colorPkg::pixelBeat_t    pixIn,
	input  colorPkg::colorWindow_t  window,
	input  logic                    highlightEn,
	output colorPkg::pixelBeat_t    pixOut,
	output logic                    inWindow
);

	logic match;
	logic validQ;
	logic inWindowQ;
	logic [colorPkg::COORD_W-1:0] xQ;
	logic [colorPkg::COORD_W-1:0] yQ;
	colorPkg::rgbPixel_t rgbQ;

	// Inclusive on both edges
	function automatic logic inRange
	(
		input logic [colorPkg::CHAN_W-1:0] val,
		input logic [colorPkg::CHAN_W-1:0] lo,
		input logic [colorPkg::CHAN_W-1:0] hi
	);
		return (val >= lo) && (val <= hi);
	endfunction

	assign match = inRange(pixIn.rgb.r, window.low.r, window.high.r)
		&& inRange(pixIn.rgb.g, window.low.g, window.high.g)
		&& inRange(pixIn.rgb.b, window.low.b, window.high.b);

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			validQ    <= 1'b0;
			inWindowQ <= 1'b0;
		end
		else
		begin
			validQ    <= pixIn.valid;
			inWindowQ <= pixIn.valid && match; // No match on idle cycles
		end
	end

	always_ff @(posedge CLK)
	begin
		xQ <= pixIn.x;
		yQ <= pixIn.y;
		if (match && highlightEn)
			rgbQ <= colorPkg::HIGHLIGHT;
		else
			rgbQ <= pixIn.rgb;
	end

	assign pixOut   = '{valid: validQ, x: xQ, y: yQ, rgb: rgbQ};
	assign inWindow = inWindowQ;

endmodule

`default_nettype wire

/* hueClassifier.sv */
`timescale 1ns/1ns
`default_nettype none

module hueClassifier
(
	input  logic                  CLK,
	input  logic                  rst,
	input  colorPkg::pixelBeat_t  pixIn,
	output colorPkg::hueFlags_t   hueFlags,
	output logic                  flagsValid
);

	logic [colorPkg::CHAN_W-1:0] r;
	logic [colorPkg::CHAN_W-1:0] g;
	logic [colorPkg::CHAN_W-1:0] b;
	logic [colorPkg::CHAN_W:0] gAndHalf; // One extra bit so nothing wraps
	logic [colorPkg::CHAN_W:0] twiceB;
	logic isRed;
	logic isYellow;
	logic isGreen;
	colorPkg::hueFlags_t flagsQ;
	logic validQ;

	assign r = pixIn.rgb.r;
	assign g = pixIn.rgb.g;
	assign b = pixIn.rgb.b;

	assign gAndHalf = {1'b0, g} + {2'b00, g[colorPkg::CHAN_W-1:1]};
	assign twiceB   = {b, 1'b0};

	// Strong red dominates both other channels
	assign isRed = (r > colorPkg::RED_MIN)
		&& (g <= colorPkg::RED_OTHER_MAX)
		&& (b <= colorPkg::RED_OTHER_MAX)
		&& ({1'b0, r} > gAndHalf)
		&& ({1'b0, r} > twiceB);

	assign isYellow = (r > colorPkg::YEL_RG_MIN)
		&& (g > colorPkg::YEL_RG_MIN)
		&& (b < colorPkg::YEL_B_MAX);

	assign isGreen = (r < colorPkg::GRN_R_MAX)
		&& (g > colorPkg::GRN_G_MIN)
		&& (b < colorPkg::GRN_B_MAX);

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			flagsQ <= '0;
			validQ <= 1'b0;
		end
		else
		begin
			flagsQ <= '{
				red:    pixIn.valid && isRed,
				yellow: pixIn.valid && isYellow,
				green:  pixIn.valid && isGreen,
				window: 1'b0 // Filled in at the top
			};
			validQ <= pixIn.valid;
		end
	end

	assign hueFlags   = flagsQ;
	assign flagsValid = validQ;

endmodule

`default_nettype wire

/* frameTally.sv */
`timescale 1ns/1ns
`default_nettype none

module frameTally
(
	input  logic                    CLK,
	input  logic                    rst,
	input  colorPkg::hueFlags_t     flags,
	input  logic                    flagsValid,
	input  logic                    frameEnd,
	output colorPkg::frameCounts_t  counts,
	output colorPkg::hueFlags_t     present,
	output logic                    tallyValid
);

	logic endQ; // Frame end, one cycle late
	colorPkg::frameCounts_t running;
	colorPkg::frameCounts_t countsQ;
	colorPkg::hueFlags_t presentNow;
	colorPkg::hueFlags_t presentQ;
	logic tallyQ;

	// Count up, stick at all ones
	function automatic logic [colorPkg::COUNT_W-1:0] satInc
	(
		input logic [colorPkg::COUNT_W-1:0] cnt,
		input logic                         hit
	);
		logic [colorPkg::COUNT_W-1:0] res;
		if (hit && (cnt != {colorPkg::COUNT_W{1'b1}}))
			res = cnt + {{(colorPkg::COUNT_W-1){1'b0}}, 1'b1};
		else
			res = cnt;
		return res;
	endfunction

	always_ff @(posedge CLK)
	begin
		if (rst)
			running <= '0;
		else if (endQ)
			running <= '0; // Fresh start for the next frame
		else if (flagsValid)
		begin
			running.red    <= satInc(running.red, flags.red);
			running.yellow <= satInc(running.yellow, flags.yellow);
			running.green  <= satInc(running.green, flags.green);
			running.window <= satInc(running.window, flags.window);
		end
	end

	always_comb
	begin
		presentNow.red    = running.red >= colorPkg::MIN_PRESENT;
		presentNow.yellow = running.yellow >= colorPkg::MIN_PRESENT;
		presentNow.green  = running.green >= colorPkg::MIN_PRESENT;
		presentNow.window = running.window >= colorPkg::MIN_PRESENT;
	end

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			endQ     <= 1'b0;
			tallyQ   <= 1'b0;
			countsQ  <= '0;
			presentQ <= '0;
		end
		else
		begin
			endQ   <= frameEnd;
			tallyQ <= endQ;
			if (endQ)
			begin
				countsQ  <= running;
				presentQ <= presentNow;
			end
		end
	end

	assign counts     = countsQ;
	assign present    = presentQ;
	assign tallyValid = tallyQ;

endmodule

`default_nettype wire

/* colorDetect.sv */
`timescale 1ns/1ns
`default_nettype none

module colorDetect
(
	input  logic                    CLK,
	input  logic                    rst,
	input  colorPkg::pixelBeat_t    pixIn,
	input  logic                    calibrate,
	input  logic                    highlightEn,
	input  logic [4:0]              tolStep,
	input  logic                    frameEnd,
	output colorPkg::rgbPixel_t     refColor,
	output colorPkg::pixelBeat_t    pixOut,
	output colorPkg::hueFlags_t     hueFlags,
	output colorPkg::frameCounts_t  counts,
	output colorPkg::hueFlags_t     present,
	output logic                    tallyValid
);

	colorPkg::colorWindow_t window;
	colorPkg::hueFlags_t classFlags;
	colorPkg::hueFlags_t mergedFlags;
	logic inWindow;
	logic flagsValid;

	refSampler sampler (
		.CLK(CLK), .rst(rst), .pixIn(pixIn), .calibrate(calibrate),
		.tolStep(tolStep), .refColor(refColor), .window(window)
	);

	// Both stages below are one cycle, so their outputs line up
	windowMatch matcher (
		.CLK(CLK), .rst(rst), .pixIn(pixIn), .window(window),
		.highlightEn(highlightEn), .pixOut(pixOut), .inWindow(inWindow)
	);

	hueClassifier classifier (
		.CLK(CLK), .rst(rst), .pixIn(pixIn),
		.hueFlags(classFlags), .flagsValid(flagsValid)
	);

	assign mergedFlags = '{
		red:    classFlags.red,
		yellow: classFlags.yellow,
		green:  classFlags.green,
		window: inWindow
	};

	frameTally tally (
		.CLK(CLK), .rst(rst), .flags(mergedFlags), .flagsValid(flagsValid),
		.frameEnd(frameEnd), .counts(counts), .present(present),
		.tallyValid(tallyValid)
	);

	assign hueFlags = mergedFlags;

endmodule

`default_nettype wire

/* colorDetectTb.sv */
`timescale 1ns/1ns
`default_nettype none

module colorDetectTb;

	localparam int CLK_PERIOD   = 40;
	localparam int RAND_CLASS_N = 400;
	localparam int RAND_FRAME_N = 200;
	localparam int RUN_CYCLES   = RAND_CLASS_N + RAND_FRAME_N + 250; // Directed part on top

	typedef struct packed {
		colorPkg::pixelBeat_t pix;
		colorPkg::hueFlags_t  flags;
		colorPkg::rgbPixel_t  refc;
	} expect_t;

	logic CLK = 1'b0;
	logic rst = 1'b1;
	colorPkg::pixelBeat_t pixIn = '0;
	logic calibrate = 1'b0;
	logic highlightEn = 1'b0;
	logic [4:0] tolStep = '0;
	logic frameEnd = 1'b0;
	colorPkg::rgbPixel_t refColor;
	colorPkg::pixelBeat_t pixOut;
	colorPkg::hueFlags_t hueFlags;
	colorPkg::frameCounts_t counts;
	colorPkg::hueFlags_t present;
	logic tallyValid;

	int seed = 88453;
	string testName = "reset";
	logic curCal = 1'b0;
	logic curHl = 1'b0;
	logic [4:0] curTol = '0;
	colorPkg::rgbPixel_t modelRef = '0;
	int modelCnt [4] = '{0, 0, 0, 0}; // Red, yellow, green, window
	int snapCnt [4] = '{0, 0, 0, 0};
	int tallyChecks = 0;
	logic [2:0] feHist = '0;
	logic tallyExp = 1'b0;
	expect_t expQ [$];

	// Pixels on both sides of each classifier threshold
	int crafted [15][3] = '{'{257, 128, 128}, '{256, 128, 128}, '{257, 129, 0},
		'{257, 0, 129}, '{1023, 128, 128}, '{257, 257, 127}, '{256, 300, 0},
		'{300, 256, 0}, '{300, 300, 128}, '{99, 141, 255}, '{100, 141, 255},
		'{99, 140, 0}, '{99, 141, 256}, '{512, 512, 512}, '{0, 0, 0}};

	colorDetect uut (
		.CLK(CLK), .rst(rst), .pixIn(pixIn), .calibrate(calibrate),
		.highlightEn(highlightEn), .tolStep(tolStep), .frameEnd(frameEnd),
		.refColor(refColor), .pixOut(pixOut), .hueFlags(hueFlags),
		.counts(counts), .present(present), .tallyValid(tallyValid)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// One pulse per frame, two cycles after the strobe
	tallyPulse: assert property (@(negedge CLK) disable iff (rst) tallyValid == tallyExp)
		else stopWithFailure($sformatf("[FAIL] %s tallyValid expected %0b actual %0b",
			testName, tallyExp, tallyValid));

	task automatic stopWithFailure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string what, input logic [127:0] expVal,
		input logic [127:0] actVal);
		assert (expVal === actVal)
			else stopWithFailure($sformatf("[FAIL] %s %s expected %0h actual %0h",
				testName, what, expVal, actVal));
	endtask

	function automatic logic [colorPkg::CHAN_W-1:0] lowEdge(input int v, input int tol);
		return (v > tol) ? v - tol : 0;
	endfunction

	function automatic logic [colorPkg::CHAN_W-1:0] highEdge(input int v, input int tol);
		return (v + tol < int'(colorPkg::CHAN_MAX)) ? v + tol : colorPkg::CHAN_MAX;
	endfunction

	function automatic colorPkg::colorWindow_t modelWindow(input colorPkg::rgbPixel_t c,
		input logic [4:0] step);
		colorPkg::colorWindow_t w;
		int tol;
		tol = int'(colorPkg::TOL_BASE) + 4 * int'(step);
		w.low  = '{r: lowEdge(c.r, tol), g: lowEdge(c.g, tol), b: lowEdge(c.b, tol)};
		w.high = '{r: highEdge(c.r, tol), g: highEdge(c.g, tol), b: highEdge(c.b, tol)};
		return w;
	endfunction

	function automatic logic insideWindow(input colorPkg::rgbPixel_t c,
		input colorPkg::colorWindow_t w);
		return (c.r >= w.low.r) && (c.r <= w.high.r) && (c.g >= w.low.g)
			&& (c.g <= w.high.g) && (c.b >= w.low.b) && (c.b <= w.high.b);
	endfunction

	function automatic colorPkg::hueFlags_t classify(input colorPkg::rgbPixel_t c);
		colorPkg::hueFlags_t f;
		int r;
		int g;
		int b;
		r = c.r;
		g = c.g;
		b = c.b;
		f.red = (r > colorPkg::RED_MIN) && (g <= colorPkg::RED_OTHER_MAX)
			&& (b <= colorPkg::RED_OTHER_MAX) && (r > g + g / 2) && (r > 2 * b);
		f.yellow = (r > colorPkg::YEL_RG_MIN) && (g > colorPkg::YEL_RG_MIN)
			&& (b < colorPkg::YEL_B_MAX);
		f.green = (r < colorPkg::GRN_R_MAX) && (g > colorPkg::GRN_G_MIN)
			&& (b < colorPkg::GRN_B_MAX);
		f.window = 1'b0;
		return f;
	endfunction

	function automatic colorPkg::pixelBeat_t makePixel(input int x, input int y,
		input int r, input int g, input int b);
		colorPkg::pixelBeat_t p;
		p.valid = 1'b1;
		p.x     = x[colorPkg::COORD_W-1:0];
		p.y     = y[colorPkg::COORD_W-1:0];
		p.rgb   = '{r: r[colorPkg::CHAN_W-1:0], g: g[colorPkg::CHAN_W-1:0],
			b: b[colorPkg::CHAN_W-1:0]};
		return p;
	endfunction

	function automatic int randChan();
		int v;
		v = $random(seed) & 1023;
		return v >> (2 * ($random(seed) & 3)); // Lean towards darker values
	endfunction

	function automatic colorPkg::pixelBeat_t randPixel();
		colorPkg::pixelBeat_t p;
		p = makePixel($random(seed), $random(seed), randChan(), randChan(), randChan());
		p.valid = ($random(seed) & 3) != 0; // Leaves idle gaps
		return p;
	endfunction

	// Drive one beat, then check the beat from the cycle before
	task automatic driveBeat(input colorPkg::pixelBeat_t p, input logic fe);
		expect_t e;
		expect_t prev;
		colorPkg::frameCounts_t ec;
		colorPkg::hueFlags_t ep;
		logic hit;
		@(posedge CLK);
		pixIn       <= p;
		calibrate   <= curCal;
		highlightEn <= curHl;
		tolStep     <= curTol;
		frameEnd    <= fe;
		hit   = p.valid && insideWindow(p.rgb, modelWindow(modelRef, curTol));
		e.pix = p;
		if (hit && curHl)
			e.pix.rgb = colorPkg::HIGHLIGHT;
		e.flags        = p.valid ? classify(p.rgb) : '0;
		e.flags.window = hit;
		if (p.valid && curCal && p.x == colorPkg::CAL_X && p.y == colorPkg::CAL_Y)
			modelRef = p.rgb;
		e.refc = modelRef;
		for (int i = 0; i < 4; i++)
			modelCnt[i] += e.flags[3 - i];
		if (fe)
		begin
			snapCnt  = modelCnt;
			modelCnt = '{0, 0, 0, 0};
		end
		feHist   = {feHist[1:0], fe};
		tallyExp = feHist[2];
		expQ.push_back(e);
		@(negedge CLK);
		prev = expQ.pop_front();
		checkValue("pixOut valid", prev.pix.valid, pixOut.valid);
		if (prev.pix.valid)
			checkValue("pixOut", prev.pix, pixOut);
		checkValue("hueFlags", prev.flags, hueFlags);
		checkValue("refColor", prev.refc, refColor);
		if (tallyExp)
		begin
			tallyChecks++;
			for (int i = 0; i < 4; i++)
			begin
				ec[(3 - i) * colorPkg::COUNT_W +: colorPkg::COUNT_W] = snapCnt[i];
				ep[3 - i] = snapCnt[i] >= colorPkg::MIN_PRESENT;
			end
			checkValue("counts", ec, counts);
			checkValue("present", ep, present);
		end
	endtask

	task automatic calibrateTo(input int r, input int g, input int b);
		curCal = 1'b1;
		driveBeat(makePixel(colorPkg::CAL_X, colorPkg::CAL_Y, r, g, b), 1'b0);
		curCal = 1'b0;
	endtask

	// Each channel at both bounds and one step outside, others at the reference
	task automatic probeBounds();
		colorPkg::colorWindow_t w;
		int base [3];
		int lo [3];
		int hi [3];
		int v [3];
		int probe [4];
		w    = modelWindow(modelRef, curTol);
		base = '{modelRef.r, modelRef.g, modelRef.b};
		lo   = '{w.low.r, w.low.g, w.low.b};
		hi   = '{w.high.r, w.high.g, w.high.b};
		for (int c = 0; c < 3; c++)
		begin
			probe = '{lo[c], hi[c], lo[c] - 1, hi[c] + 1};
			for (int k = 0; k < 4; k++)
			begin
				v    = base;
				v[c] = probe[k];
				if (v[c] >= 0 && v[c] <= int'(colorPkg::CHAN_MAX))
					driveBeat(makePixel(100, 200, v[0], v[1], v[2]), 1'b0);
			end
		end
		driveBeat(makePixel(101, 200, lo[0], lo[1], lo[2]), 1'b0);
		driveBeat(makePixel(102, 200, hi[0], hi[1], hi[2]), 1'b0);
	endtask

	initial
	begin
		#(RUN_CYCLES * CLK_PERIOD + 2000);
		stopWithFailure("Timeout: the tests did not finish in the expected time");
	end

	initial
	begin
		repeat (5) @(posedge CLK);
		rst <= 1'b0;
		expQ.push_back('0); // Idle beat seen right after reset
		@(negedge CLK);
		checkValue("pixOut valid", 1'b0, pixOut.valid);
		checkValue("tallyValid", 1'b0, tallyValid);
		checkValue("present", '0, present);
		checkValue("counts", '0, counts);

		testName = "passThrough";
		repeat (30) driveBeat(randPixel(), 1'b0);

		testName = "calibration";
		curCal = 1'b1;
		driveBeat(makePixel(colorPkg::CAL_X + 1, colorPkg::CAL_Y, 7, 7, 7), 1'b0);
		driveBeat(makePixel(colorPkg::CAL_X, colorPkg::CAL_Y + 1, 9, 9, 9), 1'b0);
		calibrateTo(500, 300, 700);
		driveBeat(makePixel(colorPkg::CAL_X, colorPkg::CAL_Y, 1, 2, 3), 1'b0);
		driveBeat('0, 1'b0);
		checkValue("refColor held", {10'd500, 10'd300, 10'd700}, refColor);
		curHl = 1'b1;
		probeBounds();

		testName = "boundsLow";
		calibrateTo(10, 50, 0);
		probeBounds();
		testName = "boundsHigh";
		curTol = 5'd31;
		calibrateTo(1020, 1000, 950);
		probeBounds();
		testName = "tolStep";
		curTol = 5'd10;
		probeBounds();

		testName = "classCrafted";
		curHl = 1'b0;
		for (int i = 0; i < 15; i++)
			driveBeat(makePixel(i, 300, crafted[i][0], crafted[i][1], crafted[i][2]), 1'b0);
		testName = "classRandom";
		for (int i = 0; i < RAND_CLASS_N; i++)
		begin
			curHl = i[5];
			driveBeat(randPixel(), 1'b0);
		end

		testName = "tallyFlush";
		driveBeat('0, 1'b1);
		repeat (3) driveBeat('0, 1'b0);
		testName = "tallyMixed";
		repeat (8) driveBeat(makePixel(5, 6, 60, 400, 30), 1'b0);
		repeat (RAND_FRAME_N) driveBeat(randPixel(), 1'b0);
		repeat (8) driveBeat(makePixel(7, 8, 600, 40, 20), 1'b0);
		driveBeat('0, 1'b1);
		repeat (3) driveBeat('0, 1'b0);
		testName = "tallyRestart";
		repeat (16) driveBeat(makePixel(5, 6, 60, 400, 30), 1'b0); // Green, just present
		repeat (15) driveBeat(makePixel(7, 8, 600, 40, 20), 1'b0); // Red, one short
		driveBeat('0, 1'b1);
		repeat (3) driveBeat('0, 1'b0);

		if (tallyChecks != 3)
			stopWithFailure("Frame tally was not reported once for every frame end");
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
colorPkg.sv
refSampler.sv
windowMatch.sv
hueClassifier.sv
frameTally.sv
colorDetect.sv
colorDetectTb.sv

/* runSim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the run from its log
LOG=runSim.log
rm -f "$LOG"
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module colorDetectTb -o colorDetectSim \
	&& ./obj_dir/colorDetectSim > "$LOG" 2>&1 \
	|| echo "Build or simulation returned an error"
cat "$LOG" 2>/dev/null
grep -q "^STATUS: PASS$" "$LOG" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
